// ==== src/exu_pkg.sv ====
package exu_pkg;

    localparam int XLEN  = 32;
    localparam int NREG  = 32;
    localparam int REG_W = 5;

    // codes 11..15 are unused and give zero
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_op_e;

    // decoded micro-op from the front end
    typedef struct packed {
        alu_op_e           op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs1;
        logic [REG_W-1:0]  rs2;
        logic              use_imm;
        logic [XLEN-1:0]   imm;
    } uop_t;

    typedef struct packed {
        logic              en;
        alu_op_e           op;
        logic [REG_W-1:0]  rd;
        logic [XLEN-1:0]   src0;
        logic [XLEN-1:0]   src1;    // imm or rs2 value
    } exec_t;

    // result as written back and sent out
    typedef struct packed {
        logic [REG_W-1:0]  rd;
        logic [XLEN-1:0]   value;
    } wb_t;

endpackage

// ==== src/uop_receiver.sv ====
`timescale 1ns/1ps

module uop_receiver import exu_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic in_req,
    input  uop_t in_uop,
    output logic in_ack,
    input  logic take,
    output logic held_valid,
    output uop_t held_uop
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RELEASE,  // ack high until req drops
        S_HOLD      // full with ack low
    } rx_state_e;

    rx_state_e state;

    assign in_ack = (state == S_RELEASE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            held_valid <= 1'b0;
            held_uop   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_req) begin
                        held_uop   <= in_uop;
                        held_valid <= 1'b1;
                        state      <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (take)
                        held_valid <= 1'b0;
                    if (!in_req)
                        state <= (held_valid && !take) ? S_HOLD : S_IDLE;
                end
                S_HOLD: begin
                    if (take) begin
                        held_valid <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage import exu_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             held_valid,
    input  uop_t             held_uop,
    output logic             take,
    output logic [REG_W-1:0] rs1,
    output logic [REG_W-1:0] rs2,
    input  logic [XLEN-1:0]  rdata1,
    input  logic [XLEN-1:0]  rdata2,
    input  logic             wb_ready,
    output exec_t            exec
);

    logic            hazard;
    logic            exec_free;
    logic [XLEN-1:0] src1_sel;

    assign rs1 = held_uop.rs1;
    assign rs2 = held_uop.rs2;

    // raw on the uop still sitting in the execute register
    assign hazard = exec.en && (exec.rd != '0) &&
                    ((exec.rd == held_uop.rs1) ||
                     (!held_uop.use_imm && (exec.rd == held_uop.rs2)));

    assign exec_free = !exec.en || wb_ready;     // empty or leaving this cycle
    assign take      = held_valid && exec_free && !hazard;

    assign src1_sel = held_uop.use_imm ? held_uop.imm : rdata2;

    always_ff @(posedge clk) begin
        if (reset) begin
            exec <= '0;
        end else if (take) begin
            exec.en   <= 1'b1;
            exec.op   <= held_uop.op;
            exec.rd   <= held_uop.rd;
            exec.src0 <= rdata1;
            exec.src1 <= src1_sel;
        end else if (wb_ready) begin
            exec.en <= 1'b0;  // result went to the sender
        end
    end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile import exu_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic [REG_W-1:0] raddr1,
    input  logic [REG_W-1:0] raddr2,
    output logic [XLEN-1:0]  rdata1,
    output logic [XLEN-1:0]  rdata2,
    input  logic             we,
    input  logic [REG_W-1:0] waddr,
    input  logic [XLEN-1:0]  wdata
);

    logic [XLEN-1:0] regs [NREG];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREG; i++)
                regs[i] <= '0;
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hard zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu import exu_pkg::*; (
    input  logic             alu_en_in,
    input  alu_op_e          alu_control,
    input  logic [REG_W-1:0] alu_rd_in,
    input  logic [XLEN-1:0]  alu_sr0,
    input  logic [XLEN-1:0]  alu_sr1,
    output logic             alu_en_out,
    output logic [REG_W-1:0] alu_rd_out,
    output logic [XLEN-1:0]  alu_result
);

    logic            inv_b;
    logic [XLEN-1:0] adder_b;
    logic [XLEN-1:0] adder_sum;
    logic            adder_cout;
    logic            slt_bit;
    logic            sltu_bit;
    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    // sub, slt and sltu all go through a + ~b + 1
    assign inv_b = (alu_control == ALU_SUB) ||
                   (alu_control == ALU_SLT) ||
                   (alu_control == ALU_SLTU);

    assign adder_b = inv_b ? ~alu_sr1 : alu_sr1;
    assign {adder_cout, adder_sum} = {1'b0, alu_sr0} + {1'b0, adder_b} +
                                     {{XLEN{1'b0}}, inv_b};

    // negative sr0 beats positive sr1 and equal signs use the sum bit
    assign slt_bit = (alu_sr0[XLEN-1] & ~alu_sr1[XLEN-1]) |
                     (~(alu_sr0[XLEN-1] ^ alu_sr1[XLEN-1]) & adder_sum[XLEN-1]);
    assign sltu_bit = ~adder_cout;  // borrow out

    assign shamt = alu_sr1[4:0];

    always_comb begin
        case (alu_control)
            ALU_ADD,
            ALU_SUB:  result = adder_sum;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, slt_bit};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, sltu_bit};
            ALU_AND:  result = alu_sr0 & alu_sr1;
            ALU_OR:   result = alu_sr0 | alu_sr1;
            ALU_NOR:  result = ~(alu_sr0 | alu_sr1);
            ALU_XOR:  result = alu_sr0 ^ alu_sr1;
            ALU_SLL:  result = alu_sr0 << shamt;
            ALU_SRL:  result = alu_sr0 >> shamt;
            ALU_SRA:  result = $unsigned($signed(alu_sr0) >>> shamt);
            default:  result = '0;  // unused codes
        endcase
    end

    assign alu_en_out = alu_en_in;
    assign alu_rd_out = alu_en_in ? alu_rd_in : '0;
    assign alu_result = alu_en_in ? result : '0;

endmodule

// ==== src/writeback_sender.sv ====
`timescale 1ns/1ps

module writeback_sender import exu_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             alu_en_out,
    input  logic [REG_W-1:0] alu_rd_out,
    input  logic [XLEN-1:0]  alu_result,
    output logic             wb_ready,
    output logic             we,
    output logic [REG_W-1:0] waddr,
    output logic [XLEN-1:0]  wdata,
    output logic             out_req,
    input  logic             out_ack,
    output wb_t              out_wb
);

    typedef enum logic [1:0] {
        S_EMPTY,
        S_FULL,   // captured and req goes up next
        S_REQ,
        S_REL     // req dropped and waiting for ack low
    } tx_state_e;

    tx_state_e state;

    assign wb_ready = (state == S_EMPTY);
    assign out_req  = (state == S_REQ);

    // register file is written on the capture edge
    assign we    = alu_en_out && wb_ready;
    assign waddr = alu_rd_out;
    assign wdata = alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_EMPTY;
            out_wb <= '0;
        end else begin
            case (state)
                S_EMPTY: begin
                    if (alu_en_out) begin
                        out_wb.rd    <= alu_rd_out;
                        out_wb.value <= alu_result;
                        state        <= S_FULL;
                    end
                end
                S_FULL:  state <= S_REQ;
                S_REQ:   if (out_ack) state <= S_REL;
                S_REL:   if (!out_ack) state <= S_EMPTY;
                default: state <= S_EMPTY;
            endcase
        end
    end

endmodule

// ==== src/int_exec_unit.sv ====
`timescale 1ns/1ps

module int_exec_unit import exu_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic in_req,
    input  uop_t in_uop,
    output logic in_ack,
    output logic out_req,
    output wb_t  out_wb,
    input  logic out_ack
);

    logic             held_valid;
    uop_t             held_uop;
    logic             take;
    logic [REG_W-1:0] rs1;
    logic [REG_W-1:0] rs2;
    logic [XLEN-1:0]  rdata1;
    logic [XLEN-1:0]  rdata2;
    logic             wb_ready;
    exec_t            exec;
    logic             alu_en_out;
    logic [REG_W-1:0] alu_rd_out;
    logic [XLEN-1:0]  alu_result;
    logic             we;
    logic [REG_W-1:0] waddr;
    logic [XLEN-1:0]  wdata;

    uop_receiver u_rx (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_uop(in_uop), .in_ack(in_ack),
        .take(take), .held_valid(held_valid), .held_uop(held_uop)
    );

    issue_stage u_issue (
        .clk(clk), .reset(reset),
        .held_valid(held_valid), .held_uop(held_uop), .take(take),
        .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
        .wb_ready(wb_ready), .exec(exec)
    );

    regfile u_rf (
        .clk(clk), .reset(reset),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rdata1), .rdata2(rdata2),
        .we(we), .waddr(waddr), .wdata(wdata)
    );

    alu u_alu (
        .alu_en_in(exec.en), .alu_control(exec.op), .alu_rd_in(exec.rd),
        .alu_sr0(exec.src0), .alu_sr1(exec.src1),
        .alu_en_out(alu_en_out), .alu_rd_out(alu_rd_out), .alu_result(alu_result)
    );

    writeback_sender u_wb (
        .clk(clk), .reset(reset),
        .alu_en_out(alu_en_out), .alu_rd_out(alu_rd_out), .alu_result(alu_result),
        .wb_ready(wb_ready), .we(we), .waddr(waddr), .wdata(wdata),
        .out_req(out_req), .out_ack(out_ack), .out_wb(out_wb)
    );

endmodule

// ==== sim/int_exec_unit_tb.sv ====
`timescale 1ns/1ps

module int_exec_unit_tb import exu_pkg::*; ();

    logic clk;
    logic reset;
    logic in_req;
    uop_t in_uop;
    logic in_ack;
    logic out_req;
    wb_t  out_wb;
    logic out_ack;

    uop_t        test_uop[$];
    wb_t         test_exp[$];
    int          pass_cnt;
    int          fail_cnt;
    int          accepted;  // uops acked on the input side
    int          drained;   // outputs released by the sender
    bit          aborted;
    logic [31:0] rng;

    int_exec_unit uut (
        .clk(clk), .reset(reset),
        .in_req(in_req), .in_uop(in_uop), .in_ack(in_ack),
        .out_req(out_req), .out_wb(out_wb), .out_ack(out_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] op, rd, rs1, rs2, use_imm, imm, expv;
        uop_t        u;
        wb_t         w;
        fd = $fopen("sim/int_exec_unit_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test vector file");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h", op, rd, rs1, rs2, use_imm, imm, expv);
            if (n == 7) begin  // comment and blank lines fall through
                u.op      = alu_op_e'(op[3:0]);
                u.rd      = rd[REG_W-1:0];
                u.rs1     = rs1[REG_W-1:0];
                u.rs2     = rs2[REG_W-1:0];
                u.use_imm = use_imm[0];
                u.imm     = imm;
                w.rd      = rd[REG_W-1:0];
                w.value   = expv;
                test_uop.push_back(u);
                test_exp.push_back(w);
            end
        end
        $fclose(fd);
    endtask

    // polls on falling edges until the signal reaches the level
    task automatic wait_level(input bit on_ack, input logic level, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 200 && !ok && !aborted; n++) begin
            @(negedge clk);
            ok = ((on_ack ? in_ack : out_req) == level);
        end
        if (!ok && !aborted) begin
            $display("timeout: %s did not go to %0d within 200 cycles",
                     on_ack ? "in_ack" : "out_req", level);
            aborted = 1'b1;
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!in_ack && !out_req) else begin
                $display("in_ack or out_req went high with no request pending");
                fail_cnt++;
            end
        end
    endtask

    task automatic send_uops();
        bit ok;
        foreach (test_uop[i]) begin
            if (aborted)
                break;
            in_uop = test_uop[i];
            in_req = 1'b1;
            wait_level(1'b1, 1'b1, ok);
            if (!ok)
                break;
            accepted++;
            // receiver, execute register and sender hold one each
            assert (accepted - drained <= 3) else begin
                $display("in_ack rose while %0d uops were still in flight",
                         accepted - drained - 1);
                fail_cnt++;
            end
            in_req = 1'b0;
            wait_level(1'b1, 1'b0, ok);
            if (!ok)
                break;
        end
    endtask

    task automatic collect_outputs();
        bit ok;
        bit good;
        int delay;
        foreach (test_exp[i]) begin
            wait_level(1'b0, 1'b1, ok);
            if (!ok)
                break;
            good = 1'b1;
            assert (out_wb.rd == test_exp[i].rd) else begin
                $display("error out_wb.rd got %h expected %h", out_wb.rd, test_exp[i].rd);
                good = 1'b0;
            end
            assert (out_wb.value == test_exp[i].value) else begin
                $display("error out_wb.value got %h expected %h",
                         out_wb.value, test_exp[i].value);
                good = 1'b0;
            end
            if (good)
                pass_cnt++;
            else
                fail_cnt++;
            $display("test %0d op %0d rd %0d: %s", i, test_uop[i].op, test_exp[i].rd,
                     good ? "ok" : "mismatch");
            rng   = xorshift32(rng);
            delay = int'(rng[2:0]);  // 0..7 cycles of sink stall
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            wait_level(1'b0, 1'b0, ok);
            if (!ok)
                break;
            out_ack = 1'b0;
            @(posedge clk);  // sender sees ack low and empties here
            drained++;
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_req   = 1'b0;
        in_uop   = '0;
        out_ack  = 1'b0;
        pass_cnt = 0;
        fail_cnt = 0;
        accepted = 0;
        drained  = 0;
        aborted  = 1'b0;
        rng      = 32'h4135c88c;
        load_tests();
        check_quiet(16);
        reset = 1'b0;
        check_quiet(3);
        fork
            send_uops();
            collect_outputs();
        join
        if (!aborted)
            check_quiet(10);  // nothing extra comes out
        $display("%0d passed, %0d failed of %0d tests", pass_cnt, fail_cnt, test_uop.size());
        if (fail_cnt == 0 && !aborted && pass_cnt > 0 && pass_cnt == test_uop.size())
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== int_exec_unit.f ====
src/exu_pkg.sv
src/uop_receiver.sv
src/issue_stage.sv
src/regfile.sv
src/alu.sv
src/writeback_sender.sv
src/int_exec_unit.sv
sim/int_exec_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f int_exec_unit.f --top-module int_exec_unit_tb \
    -o int_exec_unit_sim
./obj_dir/int_exec_unit_sim > sim.log
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// ==== sim/int_exec_unit_tests.txt ====
# op rd rs1 rs2 use_imm imm expected (all hex)
# rd doubles as the expected out_wb.rd
0 01 00 00 1 12345678 12345678
0 02 00 00 1 fffffff0 fffffff0
0 03 00 00 1 00000005 00000005
1 04 01 00 1 00000078 12345600
2 05 02 00 1 00000005 00000001
3 06 02 00 1 00000005 00000000
3 07 03 00 1 fffffff0 00000001
4 08 01 00 1 0f0f0f0f 02040608
5 09 01 00 1 f0000000 f2345678
6 0a 03 00 1 00000000 fffffffa
7 0b 01 00 1 ffffffff edcba987
8 0c 01 00 1 00000024 23456780
9 0d 02 00 1 00000004 0fffffff
a 0e 02 00 1 00000004 ffffffff
b 0f 01 00 1 00000001 00000000
0 14 01 03 0 00000000 1234567d
1 15 14 01 0 00000000 00000005
8 16 14 15 0 00000000 468acfa0
7 16 16 02 0 00000000 b9753050
2 17 16 00 0 00000000 00000001
a 18 16 17 0 00000000 dcba9828
0 00 01 00 1 00000001 12345679
3 19 00 01 0 00000000 00000001
1 1a 00 01 0 00000000 edcba988
